/* hw/arith_pkg.sv */
//------------------------------------------------
// Shared definitions for the integer arithmetic unit
// Operand and result widths, opcodes, engine latency,
// compare flag positions and the engine result word
//------------------------------------------------

package arith_pkg;

  // Operand and result widths
  localparam int DATA_WIDTH = 32;
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  // Opcodes
  localparam int OP_WIDTH = 2;
  localparam logic [OP_WIDTH-1:0] OP_MUL = 2'd0;
  localparam logic [OP_WIDTH-1:0] OP_DIV = 2'd1;
  localparam logic [OP_WIDTH-1:0] OP_CMP = 2'd2;

  // Cycles from start to product valid in the multiplier
  localparam int MULT_LATENCY = 2;

  // Step counter of the divider, wide enough to hold DATA_WIDTH
  localparam int DIV_COUNT_WIDTH = $clog2(DATA_WIDTH + 1);

  // Compare flags inside result_lo
  localparam int CMP_LT_BIT = 0;
  localparam int CMP_EQ_BIT = 1;
  localparam int CMP_GT_BIT = 2;

  // Engine result word
  // Multiply reads it as one 64-bit product
  // Divide reads it as a pair, [1] remainder and [0] quotient
  typedef union packed {
    logic [PROD_WIDTH-1:0]      product;
    logic [1:0][DATA_WIDTH-1:0] quot_rem;
  } arith_result_t;

endpackage

/* hw/operand_if.sv */
//------------------------------------------------
// Latched request from the request registers to the
// multiply/divide engines and the result stage
//------------------------------------------------

`timescale 1ns/1ps

interface operand_if import arith_pkg::*; ();

  logic                  start;
  logic [OP_WIDTH-1:0]   op;
  logic                  is_signed;
  logic [DATA_WIDTH-1:0] left;
  logic [DATA_WIDTH-1:0] right;
  logic [DATA_WIDTH-1:0] left_mag;
  logic [DATA_WIDTH-1:0] right_mag;
  logic                  left_neg;
  logic                  right_neg;

  modport regs (output start, op, is_signed, left, right,
                output left_mag, right_mag, left_neg, right_neg);

  modport engine (input start, op, is_signed, left, right, left_mag, right_mag);

  modport result (input start, op, is_signed, left, right,
                  input right_mag, left_neg, right_neg);

endinterface

/* hw/request_regs.sv */
//------------------------------------------------
// Host side of the arithmetic unit
// Four-phase req/ack handshake, request latch and
// sign/magnitude preparation of the operands
//------------------------------------------------

`timescale 1ns/1ps

module request_regs import arith_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic [OP_WIDTH-1:0]   op,
  input  logic                  is_signed,
  input  logic [DATA_WIDTH-1:0] left,
  input  logic [DATA_WIDTH-1:0] right,
  input  logic                  result_done,
  output logic                  ack,
  operand_if.regs               opr
);

  logic                  busy;
  logic                  prep;
  logic                  idle;
  logic                  accept;
  logic                  next_left_neg;
  logic                  next_right_neg;
  logic [DATA_WIDTH-1:0] next_left_mag;
  logic [DATA_WIDTH-1:0] next_right_mag;

  // Idle means neither computing nor waiting for the host to drop req
  assign idle   = !busy && !ack;
  assign accept = idle && req;

  // Handshake state
  // prep marks the cycle in which the magnitudes are formed
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      ack       <= 1'b0;
      prep      <= 1'b0;
      opr.start <= 1'b0;
    end else begin
      prep      <= accept;
      opr.start <= prep;
      if (accept) begin
        busy <= 1'b1;
      end else if (result_done) begin
        busy <= 1'b0;
      end
      if (result_done) begin
        ack <= 1'b1;
      end else if (!req) begin
        ack <= 1'b0;
      end
    end
  end

  // Raw request, held until the next accepted req
  always_ff @(posedge clk) begin
    if (accept) begin
      opr.op        <= op;
      opr.is_signed <= is_signed;
      opr.left      <= left;
      opr.right     <= right;
    end
  end

  // Two's-complement magnitude only for negative signed operands
  assign next_left_neg  = opr.is_signed && opr.left[DATA_WIDTH-1];
  assign next_right_neg = opr.is_signed && opr.right[DATA_WIDTH-1];
  assign next_left_mag  = next_left_neg ? -opr.left : opr.left;
  assign next_right_mag = next_right_neg ? -opr.right : opr.right;

  always_ff @(posedge clk) begin
    if (prep) begin
      opr.left_neg  <= next_left_neg;
      opr.right_neg <= next_right_neg;
      opr.left_mag  <= next_left_mag;
      opr.right_mag <= next_right_mag;
    end
  end

  // A start belongs to the request still being worked on
  assert property (@(posedge clk) disable iff (reset)
    opr.start |-> busy && !ack);

  // Results only come back while an operation is in flight
  assert property (@(posedge clk) disable iff (reset)
    result_done |-> busy);

endmodule

/* hw/mult_pipe.sv */
//------------------------------------------------
// Two-stage 32x32 multiplier, signed or unsigned,
// returning the full 64-bit product
//------------------------------------------------

`timescale 1ns/1ps

module mult_pipe import arith_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  operand_if.engine     opr,
  output logic          done,
  output arith_result_t product
);

  logic                    go;
  logic [MULT_LATENCY-1:0] done_pipe;
  logic [PROD_WIDTH-1:0]   left_ext;
  logic [PROD_WIDTH-1:0]   right_ext;

  assign go = opr.start && opr.op == OP_MUL;

  // Valid bit walks beside the data, one bit per stage
  always_ff @(posedge clk) begin
    if (reset) begin
      done_pipe <= '0;
    end else begin
      done_pipe <= {done_pipe[MULT_LATENCY-2:0], go};
    end
  end

  assign done = done_pipe[MULT_LATENCY-1];

  // Stage 1: widen the operands to product width
  always_ff @(posedge clk) begin
    if (go) begin
      if (opr.is_signed) begin
        left_ext  <= {{DATA_WIDTH{opr.left[DATA_WIDTH-1]}}, opr.left};
        right_ext <= {{DATA_WIDTH{opr.right[DATA_WIDTH-1]}}, opr.right};
      end else begin
        left_ext  <= {{DATA_WIDTH{1'b0}}, opr.left};
        right_ext <= {{DATA_WIDTH{1'b0}}, opr.right};
      end
    end
  end

  // Stage 2: the low 64 bits of the widened product are exact
  // for both signed and unsigned operands
  always_ff @(posedge clk) begin
    if (done_pipe[0]) begin
      product.product <= left_ext * right_ext;
    end
  end

endmodule

/* hw/div_restoring.sv */
//------------------------------------------------
// Sequential restoring divider on operand magnitudes
// One quotient bit per cycle, early exit on a zero
// dividend
//------------------------------------------------

`timescale 1ns/1ps

module div_restoring import arith_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  operand_if.engine     opr,
  output logic          done,
  output arith_result_t quot_rem
);

  logic                       go;
  logic                       dividend_is_zero;
  logic                       running;
  logic                       finished;
  logic                       fits;
  logic [DATA_WIDTH-1:0]      dividend;
  logic [DATA_WIDTH-1:0]      quotient;
  logic [DATA_WIDTH-1:0]      quot_mask;
  logic [2*DATA_WIDTH-2:0]    divisor;
  logic [DIV_COUNT_WIDTH-1:0] step;

  assign go               = opr.start && opr.op == OP_DIV && !running;
  assign dividend_is_zero = go && opr.left_mag == '0;
  assign finished         = running && step == DIV_COUNT_WIDTH'(DATA_WIDTH - 1);

  // Divisor aligned so it fits under the remaining dividend
  assign fits = divisor <= {{(DATA_WIDTH-1){1'b0}}, dividend};

  // Control
  // The last step runs in the same cycle that raises done
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      done    <= 1'b0;
      step    <= '0;
    end else begin
      done <= finished || dividend_is_zero;
      if (go && !dividend_is_zero) begin
        running <= 1'b1;
        step    <= '0;
      end else if (finished) begin
        running <= 1'b0;
      end else if (running) begin
        step <= step + 1'b1;
      end
    end
  end

  // Datapath
  // A zero divisor always fits, which gives an all-ones quotient
  // and leaves the dividend as remainder
  always_ff @(posedge clk) begin
    if (go) begin
      dividend  <= opr.left_mag;
      divisor   <= {opr.right_mag, {(DATA_WIDTH-1){1'b0}}};
      quotient  <= '0;
      quot_mask <= {1'b1, {(DATA_WIDTH-1){1'b0}}};
    end else if (running) begin
      if (fits) begin
        dividend <= dividend - divisor[DATA_WIDTH-1:0];
        quotient <= quotient | quot_mask;
      end
      divisor   <= divisor >> 1;
      quot_mask <= quot_mask >> 1;
    end
  end

  // Result pair, remainder above quotient
  // A zero dividend loads as zero remainder and zero quotient
  assign quot_rem.quot_rem = {dividend, quotient};

  // A finished division leaves a remainder below the divisor
  assert property (@(posedge clk) disable iff (reset)
    done && opr.right_mag != '0 |-> quot_rem.quot_rem[1] < opr.right_mag);

endmodule

/* hw/result_stage.sv */
//------------------------------------------------
// Result stage of the arithmetic unit
// Compare flags, signed divide correction and the
// held result register
//------------------------------------------------

`timescale 1ns/1ps

module result_stage import arith_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  operand_if.result     opr,
  input  logic          mult_done,
  input  logic          div_done,
  input  arith_result_t product,
  input  arith_result_t quot_rem,
  output logic          result_done,
  output arith_result_t result
);

  logic                  cmp_go;
  logic                  any_done;
  logic                  lt;
  logic                  eq;
  logic                  gt;
  logic                  diff_signs;
  logic [DATA_WIDTH-1:0] q_mag;
  logic [DATA_WIDTH-1:0] r_mag;
  logic [DATA_WIDTH-1:0] r_adj;
  logic [DATA_WIDTH-1:0] quot_fix;
  logic [DATA_WIDTH-1:0] rem_fix;
  arith_result_t         next_result;

  // Compare needs no engine and finishes right after start
  assign cmp_go   = opr.start && opr.op == OP_CMP;
  assign any_done = mult_done || div_done || cmp_go;

  always_comb begin
    eq = opr.left == opr.right;
    if (opr.is_signed) begin
      lt = $signed(opr.left) < $signed(opr.right);
    end else begin
      lt = opr.left < opr.right;
    end
    gt = !lt && !eq;
  end

  // Quotient truncates toward zero
  // Remainder follows the divisor sign
  assign q_mag      = quot_rem.quot_rem[0];
  assign r_mag      = quot_rem.quot_rem[1];
  assign diff_signs = opr.left_neg ^ opr.right_neg;
  assign quot_fix   = diff_signs ? -q_mag : q_mag;
  assign r_adj      = (diff_signs && r_mag != '0) ? opr.right_mag - r_mag : r_mag;
  assign rem_fix    = opr.right_neg ? -r_adj : r_adj;

  always_comb begin
    next_result.product = '0;
    if (mult_done) begin
      next_result.product = product.product;
    end else if (div_done) begin
      next_result.quot_rem = {rem_fix, quot_fix};
    end else begin
      next_result.product[CMP_LT_BIT] = lt;
      next_result.product[CMP_EQ_BIT] = eq;
      next_result.product[CMP_GT_BIT] = gt;
    end
  end

  // Held until the next operation completes
  always_ff @(posedge clk) begin
    if (reset) begin
      result_done <= 1'b0;
      result      <= '0;
    end else begin
      result_done <= any_done;
      if (any_done) begin
        result <= next_result;
      end
    end
  end

  // Engines and compare never finish in the same cycle
  assert property (@(posedge clk) disable iff (reset)
    $onehot0({mult_done, div_done, cmp_go}));

endmodule

/* hw/arith_unit.sv */
//------------------------------------------------
// Top level of the 32-bit integer arithmetic unit
// Multiply, divide and compare behind a four-phase
// req/ack host port
//------------------------------------------------

`timescale 1ns/1ps

module arith_unit import arith_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  output logic                  ack,
  input  logic [OP_WIDTH-1:0]   op,
  input  logic                  is_signed,
  input  logic [DATA_WIDTH-1:0] left,
  input  logic [DATA_WIDTH-1:0] right,
  output logic [DATA_WIDTH-1:0] result_hi,
  output logic [DATA_WIDTH-1:0] result_lo
);

  logic          mult_done;
  logic          div_done;
  logic          result_done;
  arith_result_t product;
  arith_result_t quot_rem;
  arith_result_t result;

  operand_if opr_if ();

  request_regs request_regs_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .op          (op),
    .is_signed   (is_signed),
    .left        (left),
    .right       (right),
    .result_done (result_done),
    .ack         (ack),
    .opr         (opr_if.regs)
  );

  mult_pipe mult_pipe_i (
    .clk     (clk),
    .reset   (reset),
    .opr     (opr_if.engine),
    .done    (mult_done),
    .product (product)
  );

  div_restoring div_restoring_i (
    .clk      (clk),
    .reset    (reset),
    .opr      (opr_if.engine),
    .done     (div_done),
    .quot_rem (quot_rem)
  );

  result_stage result_stage_i (
    .clk         (clk),
    .reset       (reset),
    .opr         (opr_if.result),
    .mult_done   (mult_done),
    .div_done    (div_done),
    .product     (product),
    .quot_rem    (quot_rem),
    .result_done (result_done),
    .result      (result)
  );

  // Remainder or product high word on top, quotient or low word below
  assign result_hi = result.product[PROD_WIDTH-1:DATA_WIDTH];
  assign result_lo = result.product[DATA_WIDTH-1:0];

endmodule

/* testbench/tb_arith_unit.sv */
//--------------------------------------------------
// Testbench for the integer arithmetic unit
// Reference model, LCG stimulus, four-phase host
// transactions with result and timing checks
//--------------------------------------------------

`timescale 1ns/1ps

module tb_arith_unit import arith_pkg::*; ();

  localparam int MUL_RANDOM   = 200;
  localparam int DIV_RANDOM   = 60;
  localparam int SDIV_PER_MIX = 20;
  localparam int NUM_TRANS    = 3 + 32 + MUL_RANDOM + DIV_RANDOM + 3 + 4 * SDIV_PER_MIX + 14;
  localparam int CYCLE_LIMIT  = NUM_TRANS * (DATA_WIDTH + 10) + 500;

  logic                  clk;
  logic                  reset;
  logic                  req;
  logic                  ack;
  logic [OP_WIDTH-1:0]   op;
  logic                  is_signed;
  logic [DATA_WIDTH-1:0] left;
  logic [DATA_WIDTH-1:0] right;
  logic [DATA_WIDTH-1:0] result_hi;
  logic [DATA_WIDTH-1:0] result_lo;

  logic [31:0] rng_state = 32'hff42_6615;
  int          cycle_count = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_checks;
  int          test_errors;

  arith_unit dut_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .ack       (ack),
    .op        (op),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .result_hi (result_hi),
    .result_lo (result_lo)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Hang guard, sized for the slowest divide on every transaction
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the DUT did not finish within %0d cycles and seems to hang",
               CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int short_delay();
    return int'(next_random() % 4);
  endfunction

  // Expected {result_hi, result_lo}
  // Divide truncates toward zero, remainder follows the divisor sign
  function automatic logic [PROD_WIDTH-1:0] expected_result(
    input logic [OP_WIDTH-1:0]   op_in,
    input logic                  sgn,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b
  );
    longint                sa;
    longint                sb;
    longint                q;
    longint                m;
    logic [DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0] lo;
    logic [PROD_WIDTH-1:0] prod;
    sa = sgn ? longint'($signed(a)) : longint'(a);
    sb = sgn ? longint'($signed(b)) : longint'(b);
    hi = '0;
    lo = '0;
    if (op_in == OP_MUL) begin
      prod = sa * sb;
      hi   = prod[PROD_WIDTH-1:DATA_WIDTH];
      lo   = prod[DATA_WIDTH-1:0];
    end else if (op_in == OP_DIV) begin
      if (b == '0) begin
        hi = a;
        lo = '1;
      end else begin
        q = sa / sb;
        m = sa % sb;
        if (m != 0 && ((m < 0) != (sb < 0))) begin
          m = m + sb;
        end
        hi = m[DATA_WIDTH-1:0];
        lo = q[DATA_WIDTH-1:0];
      end
    end else begin
      lo[CMP_LT_BIT] = sa < sb;
      lo[CMP_EQ_BIT] = sa == sb;
      lo[CMP_GT_BIT] = sa > sb;
    end
    return {hi, lo};
  endfunction

  task automatic open_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic close_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  // One four-phase transaction, host holds req for hold_cycles after ack
  task automatic run_transaction(
    input logic [OP_WIDTH-1:0]   op_in,
    input logic                  sgn,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b,
    input int                    hold_cycles
  );
    logic [PROD_WIDTH-1:0] expected;
    logic [DATA_WIDTH-1:0] held_hi;
    logic [DATA_WIDTH-1:0] held_lo;
    int                    latency;
    expected = expected_result(op_in, sgn, a, b);
    @(negedge clk);
    checks++;
    if (ack !== 1'b0) begin
      $display("ERROR at %0t: ack high while idle", $time);
      errors++;
    end
    @(posedge clk);
    req       <= 1'b1;
    op        <= op_in;
    is_signed <= sgn;
    left      <= a;
    right     <= b;
    // DUT samples req on this edge
    @(posedge clk);
    latency = 0;
    @(negedge clk);
    while (!ack) begin
      @(posedge clk);
      latency++;
      @(negedge clk);
    end
    checks++;
    if ((op_in == OP_MUL && latency != 5) || (op_in == OP_CMP && latency != 3) ||
        (op_in == OP_DIV && latency > DATA_WIDTH + 4) ||
        (op_in == OP_DIV && a == '0 && latency != 4)) begin
      $display("ERROR at %0t: op %0d ack after %0d cycles", $time, op_in, latency);
      errors++;
    end
    checks += 2;
    if (result_hi !== expected[PROD_WIDTH-1:DATA_WIDTH]) begin
      $display("ERROR at %0t: op %0d signed %0b %h, %h result_hi %h expected %h", $time,
               op_in, sgn, a, b, result_hi, expected[PROD_WIDTH-1:DATA_WIDTH]);
      errors++;
    end
    if (result_lo !== expected[DATA_WIDTH-1:0]) begin
      $display("ERROR at %0t: op %0d signed %0b %h, %h result_lo %h expected %h", $time,
               op_in, sgn, a, b, result_lo, expected[DATA_WIDTH-1:0]);
      errors++;
    end
    held_hi = result_hi;
    held_lo = result_lo;
    for (int i = 0; i < hold_cycles; i++) begin
      @(negedge clk);
      checks++;
      if (ack !== 1'b1 || result_hi !== held_hi || result_lo !== held_lo) begin
        $display("ERROR at %0t: ack or results changed while req still high", $time);
        errors++;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    checks++;
    if (ack !== 1'b1) begin
      $display("ERROR at %0t: ack fell before req was sampled low", $time);
      errors++;
    end
    @(negedge clk);
    checks++;
    if (ack !== 1'b0 || result_hi !== held_hi || result_lo !== held_lo) begin
      $display("ERROR at %0t: ack still high or results lost after req fell", $time);
      errors++;
    end
  endtask

  initial begin
    logic [DATA_WIDTH-1:0] corner [4];
    logic [DATA_WIDTH-1:0] cmp_a [7];
    logic [DATA_WIDTH-1:0] cmp_b [7];
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] mag_a;
    logic [DATA_WIDTH-1:0] mag_b;
    corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    cmp_a  = '{32'hffff_ffff, 32'h0000_0001, 32'h8000_0000, 32'h7fff_ffff,
               32'h1234_5678, 32'hffff_ffff, 32'h0000_0000};
    cmp_b  = '{32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000,
               32'h1234_5678, 32'hffff_ffff, 32'h8000_0000};
    reset     = 1'b1;
    req       = 1'b0;
    op        = OP_MUL;
    is_signed = 1'b0;
    left      = '0;
    right     = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // ack must stay low out of reset and with req low
    open_test();
    repeat (3) begin
      @(negedge clk);
      checks++;
      if (ack !== 1'b0) begin
        $display("ERROR at %0t: ack high after reset with req low", $time);
        errors++;
      end
    end
    run_transaction(OP_MUL, 1'b1, next_random(), next_random(), 8 + int'(next_random() % 8));
    run_transaction(OP_CMP, 1'b0, next_random(), next_random(), 8 + int'(next_random() % 8));
    run_transaction(OP_DIV, 1'b0, next_random(), next_random() >> 8, 12);
    close_test("handshake");

    open_test();
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          run_transaction(OP_MUL, s[0], corner[i], corner[j], short_delay());
        end
      end
    end
    close_test("mul corners");

    open_test();
    for (int i = 0; i < MUL_RANDOM; i++) begin
      run_transaction(OP_MUL, i[0], next_random(), next_random(), short_delay());
    end
    close_test("mul random");

    open_test();
    for (int i = 0; i < DIV_RANDOM; i++) begin
      a = next_random();
      b = next_random() >> (next_random() % 32);
      if (b == '0) begin
        b = 32'd1;
      end
      run_transaction(OP_DIV, 1'b0, a, b, short_delay());
    end
    run_transaction(OP_DIV, 1'b0, 32'h0, next_random() | 32'd1, short_delay());
    run_transaction(OP_DIV, 1'b0, next_random() | 32'd1, 32'h0, short_delay());
    run_transaction(OP_DIV, 1'b0, 32'hffff_ffff, 32'h0, short_delay());
    close_test("div unsigned");

    // Every sign combination of dividend and divisor
    open_test();
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < SDIV_PER_MIX; i++) begin
        mag_a = next_random() & 32'h7fff_ffff;
        mag_b = (next_random() & 32'h7fff_ffff) >> (next_random() % 31);
        if (mag_b == '0) begin
          mag_b = 32'd1;
        end
        a = k[1] ? -mag_a : mag_a;
        b = k[0] ? -mag_b : mag_b;
        run_transaction(OP_DIV, 1'b1, a, b, short_delay());
      end
    end
    close_test("div signed");

    open_test();
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 7; i++) begin
        run_transaction(OP_CMP, s[0], cmp_a[i], cmp_b[i], short_delay());
      end
    end
    close_test("compare");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/arith_pkg.sv
hw/operand_if.sv
hw/request_regs.sv
hw/mult_pipe.sv
hw/div_restoring.sv
hw/result_stage.sv
hw/arith_unit.sv
testbench/tb_arith_unit.sv

/* Makefile */
# Verilator build, run and lint for the arithmetic unit

VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_arith_unit
RTL_TOP    = arith_unit
FILE_LIST  = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = SOME TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
